/* compile.f */
rtl/minimips_pkg.sv
rtl/minimips_ifs.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/exe_stage.sv
rtl/minimips_core.sv
sim/minimips_asserts.sv
sim/tb_minimips.sv

/* Makefile */
TOOL      = verilator
TOP       = tb_minimips
FILELIST  = compile.f
FLAGS     = --timing --assert --timescale 1ns/1ps
BUILD_DIR = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_minimips.sv */
`default_nettype none

module tb_minimips;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC = 32'hbfc00000;
    localparam int N_INSTR      = 400;
    localparam int MAX_LAT      = 3;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_NS  = N_INSTR * 5 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    localparam int N_TESTS = 6;
    localparam int T_RR    = 0;
    localparam int T_IMM   = 1;
    localparam int T_FWD   = 2;
    localparam int T_ORDER = 3;
    localparam int T_COUNT = 4;
    localparam int T_ADDR  = 5;

    // mips encodings
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] F_SLL       = 6'h00;
    localparam logic [5:0] F_ADDU      = 6'h21;
    localparam logic [5:0] F_SUBU      = 6'h23;
    localparam logic [5:0] F_AND       = 6'h24;
    localparam logic [5:0] F_OR        = 6'h25;
    localparam logic [5:0] F_XOR       = 6'h26;
    localparam logic [5:0] F_SLT       = 6'h2a;

    logic        cpu_clk_50m;
    logic        rst_n;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_data_ok;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] rng_state;
    logic [31:0] prog [N_INSTR];
    logic [31:0] model_rf [32];
    int          last_writer [32];
    logic [31:0] exp_pc_q [$];
    logic [4:0]  exp_num_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_tag_q [$];
    int          n_expected;
    int          n_observed;
    int          wait_left;
    int          mem_lat;
    logic [31:0] fetch_addr;
    int          checks [N_TESTS];
    int          errors [N_TESTS];
    string       test_name [N_TESTS];

    minimips_core #(.RESET_PC(RESET_PC)) i_dut (
        .cpu_clk_50m_i      (cpu_clk_50m),
        .rst_n_i            (rst_n),
        .inst_req_o         (inst_req),
        .inst_addr_o        (inst_addr),
        .inst_rdata_i       (inst_rdata),
        .inst_data_ok_i     (inst_data_ok),
        .debug_wb_pc_o      (debug_wb_pc),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata)
    );

    always #(CLK_PERIOD / 2) cpu_clk_50m = ~cpu_clk_50m;

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {16'h0000, rng_state[31:16]}; // the low lcg bits repeat quickly
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = rand_next();
        if (r[15:13] != 3'b000) begin
            return {2'b00, r[2:0]}; // mostly r0..r7 for dense dependencies
        end
        return r[4:0];
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [31:0] r;
        logic [15:0] imm;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        rs = pick_reg();
        rt = pick_reg();
        rd = pick_reg();
        r = rand_next();
        imm = r[15:0];
        r = rand_next();
        if (r % 100 < 10) begin
            op = r[5:0];
            if (op inside {OPC_SPECIAL, OPC_ADDIU, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI}) begin
                op = OPC_LW;
            end
            return {op, rs, rt, imm};
        end
        case (r % 12)
            0:       return {OPC_SPECIAL, rs, rt, rd, 5'd0, F_ADDU};
            1:       return {OPC_SPECIAL, rs, rt, rd, 5'd0, F_SUBU};
            2:       return {OPC_SPECIAL, rs, rt, rd, 5'd0, F_AND};
            3:       return {OPC_SPECIAL, rs, rt, rd, 5'd0, F_OR};
            4:       return {OPC_SPECIAL, rs, rt, rd, 5'd0, F_XOR};
            5:       return {OPC_SPECIAL, rs, rt, rd, 5'd0, F_SLT};
            6:       return {OPC_SPECIAL, 5'd0, rt, rd, imm[4:0], F_SLL};
            7:       return {OPC_ADDIU, rs, rt, imm};
            8:       return {OPC_ANDI, rs, rt, imm};
            9:       return {OPC_ORI, rs, rt, imm};
            10:      return {OPC_XORI, rs, rt, imm};
            default: return {OPC_LUI, 5'd0, rt, imm};
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = (addr - RESET_PC) >> 2;
        if (offs < 32'(N_INSTR)) begin
            return prog[int'(offs)];
        end
        return 32'h0000_0000; // nop past the end of the program
    endfunction

    // queues every register write of the program in order
    task automatic run_model();
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic        writes;
        logic        use_rs;
        logic        use_rt;
        logic        dep;
        for (int i = 0; i < N_INSTR; i++) begin
            inst   = prog[i];
            op     = inst[31:26];
            rs     = inst[25:21];
            rt     = inst[20:16];
            a      = model_rf[rs];
            b      = model_rf[rt];
            sext   = {{16{inst[15]}}, inst[15:0]};
            zext   = {16'h0000, inst[15:0]};
            writes = 1'b1;
            use_rs = 1'b1;
            use_rt = 1'b0;
            dst    = rt;
            res    = '0;
            case (op)
                OPC_SPECIAL: begin
                    dst    = inst[15:11];
                    use_rt = 1'b1;
                    case (inst[5:0])
                        F_ADDU:  res = a + b;
                        F_SUBU:  res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_XOR:   res = a ^ b;
                        F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F_SLL: begin
                            res    = b << inst[10:6];
                            use_rs = 1'b0;
                        end
                        default: writes = 1'b0;
                    endcase
                end
                OPC_ADDIU: res = a + sext;
                OPC_ANDI:  res = a & zext;
                OPC_ORI:   res = a | zext;
                OPC_XORI:  res = a ^ zext;
                OPC_LUI: begin
                    res    = {inst[15:0], 16'h0000};
                    use_rs = 1'b0;
                end
                default:   writes = 1'b0;
            endcase
            // operand produced by one of the two instructions just before
            dep = (use_rs && rs != 5'd0 && last_writer[rs] >= i - 2) ||
                  (use_rt && rt != 5'd0 && last_writer[rt] >= i - 2);
            if (writes && dst != 5'd0) begin
                model_rf[dst]    = res;
                last_writer[dst] = i;
                exp_pc_q.push_back(RESET_PC + 32'(i) * 32'd4);
                exp_num_q.push_back(dst);
                exp_data_q.push_back(res);
                exp_tag_q.push_back(dep ? T_FWD : ((op == OPC_SPECIAL) ? T_RR : T_IMM));
            end
        end
        n_expected = exp_pc_q.size();
    endtask

    task automatic check_write();
        logic [31:0] e_pc;
        logic [31:0] e_data;
        logic [4:0]  e_num;
        int          tag;
        n_observed++;
        if (exp_pc_q.size() == 0) begin
            errors[T_COUNT]++;
            $display("FAIL %s: expected %0d writes, actual extra write at pc %h",
                     test_name[T_COUNT], n_expected, debug_wb_pc);
            return;
        end
        e_pc   = exp_pc_q.pop_front();
        e_num  = exp_num_q.pop_front();
        e_data = exp_data_q.pop_front();
        tag    = exp_tag_q.pop_front();
        checks[T_ORDER]++;
        if (debug_wb_pc != e_pc || debug_wb_rf_wnum != e_num || debug_wb_rf_wen != 4'hf) begin
            errors[T_ORDER]++;
            $display("FAIL %s: expected pc %h r%0d wen f, actual pc %h r%0d wen %h",
                     test_name[T_ORDER], e_pc, e_num, debug_wb_pc, debug_wb_rf_wnum,
                     debug_wb_rf_wen);
        end
        checks[tag]++;
        if (debug_wb_rf_wdata != e_data) begin
            errors[tag]++;
            $display("FAIL %s: pc %h r%0d expected %h, actual %h",
                     test_name[tag], e_pc, e_num, e_data, debug_wb_rf_wdata);
        end
    endtask

    // sram-like instruction memory with 0 to MAX_LAT wait cycles per request
    always @(posedge cpu_clk_50m) begin
        if (inst_req && inst_data_ok) begin
            checks[T_ADDR]++;
            if (inst_addr != fetch_addr) begin
                errors[T_ADDR]++;
                $display("FAIL %s: expected address %h, actual %h",
                         test_name[T_ADDR], fetch_addr, inst_addr);
            end
            fetch_addr = fetch_addr + 32'd4;
            mem_lat = int'(rand_next() % (MAX_LAT + 1));
            if (mem_lat == 0) begin
                inst_rdata <= fetch_word(fetch_addr); // data_ok stays up for back to back
            end else begin
                inst_data_ok <= 1'b0;
                wait_left    <= mem_lat - 1;
            end
        end else if (inst_req) begin
            if (wait_left == 0) begin
                inst_data_ok <= 1'b1;
                inst_rdata   <= fetch_word(inst_addr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(negedge cpu_clk_50m) begin
        if (rst_n && debug_wb_rf_wen != 4'h0) begin
            check_write();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the core did not retire all %0d expected writes in time", n_expected);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int n_pass;
        int n_fail;
        cpu_clk_50m  = 1'b0;
        rst_n        = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata   = '0;
        rng_state    = 32'hdcc8;
        n_observed   = 0;
        wait_left    = 0;
        fetch_addr   = RESET_PC;
        test_name[T_RR]    = "rr_ops";
        test_name[T_IMM]   = "imm_ops";
        test_name[T_FWD]   = "forwarding";
        test_name[T_ORDER] = "retire_order";
        test_name[T_COUNT] = "write_count";
        test_name[T_ADDR]  = "fetch_addr";
        for (int t = 0; t < N_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        for (int r = 0; r < 32; r++) begin
            model_rf[r]    = '0;
            last_writer[r] = -10;
        end
        for (int i = 0; i < N_INSTR; i++) begin
            prog[i] = gen_instr();
        end
        run_model();

        // first request may see data_ok in its very first cycle
        mem_lat = int'(rand_next() % (MAX_LAT + 1));
        if (mem_lat == 0) begin
            inst_data_ok = 1'b1;
            inst_rdata   = fetch_word(RESET_PC);
        end else begin
            wait_left = mem_lat - 1;
        end

        repeat (RESET_CYCLES) @(posedge cpu_clk_50m);
        rst_n <= 1'b1;

        while (n_observed < n_expected) begin
            @(posedge cpu_clk_50m);
        end
        repeat (8) @(posedge cpu_clk_50m); // late duplicates would show up here

        checks[T_COUNT]++;
        if (n_observed != n_expected) begin
            errors[T_COUNT]++;
            $display("FAIL %s: expected %0d writes, actual %0d",
                     test_name[T_COUNT], n_expected, n_observed);
        end

        n_pass = 0;
        n_fail = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            if (errors[t] == 0) begin
                n_pass++;
            end else begin
                n_fail++;
            end
            $display("test %s: %s, %0d checks, %0d errors", test_name[t],
                     (errors[t] == 0) ? "pass" : "fail", checks[t], errors[t]);
        end
        if (i_dut.u_asserts.fail_count == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test protocol: %s, %0d assertion failures",
                 (i_dut.u_asserts.fail_count == 0) ? "pass" : "fail",
                 i_dut.u_asserts.fail_count);
        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/minimips_asserts.sv */
`default_nettype none

module minimips_asserts (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        inst_req_i,
    input logic [31:0] inst_addr_i,
    input logic        inst_data_ok_i,
    input logic [3:0]  debug_wb_rf_wen_i,
    input logic [4:0]  debug_wb_rf_wnum_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        inst_req_i |-> (inst_addr_i[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("instruction address %h is not word aligned", inst_addr_i);
        end

    // a pending request holds until data_ok completes it
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (inst_req_i && !inst_data_ok_i) |=> (inst_req_i && $stable(inst_addr_i)))
        else begin
            fail_count++;
            $error("instruction request dropped or address changed while pending");
        end

    a_wnum_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (debug_wb_rf_wen_i != 4'h0) |-> (debug_wb_rf_wnum_i != 5'd0))
        else begin
            fail_count++;
            $error("writeback trace shows a write to r0");
        end

endmodule

bind minimips_core minimips_asserts u_asserts (
    .clk_i             (cpu_clk_50m_i),
    .rst_n_i           (rst_n_i),
    .inst_req_i        (inst_req_o),
    .inst_addr_i       (inst_addr_o),
    .inst_data_ok_i    (inst_data_ok_i),
    .debug_wb_rf_wen_i (debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_i(debug_wb_rf_wnum_o)
);

`default_nettype wire

/* rtl/minimips_core.sv */
`default_nettype none

module minimips_core #(
    parameter minimips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_n_i,

    output logic                    inst_req_o,
    output minimips_pkg::word_t     inst_addr_o,
    input  minimips_pkg::word_t     inst_rdata_i,
    input  logic                    inst_data_ok_i,

    output minimips_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]              debug_wb_rf_wen_o,
    output minimips_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output minimips_pkg::word_t     debug_wb_rf_wdata_o
);

    logic                    if_valid;
    minimips_pkg::word_t     if_inst;
    minimips_pkg::word_t     if_pc;

    minimips_pkg::reg_addr_t ra1;
    minimips_pkg::reg_addr_t ra2;
    minimips_pkg::word_t     rd1;
    minimips_pkg::word_t     rd2;

    logic                    exe_fwd_wreg;
    minimips_pkg::reg_addr_t exe_fwd_wa;
    minimips_pkg::word_t     exe_fwd_wd;

    id_exe_if id_exe ();
    exe_wb_if exe_wb ();

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .cpu_clk_50m_i(cpu_clk_50m_i), .rst_n_i(rst_n_i),
        .inst_req_o(inst_req_o), .inst_addr_o(inst_addr_o),
        .inst_rdata_i(inst_rdata_i), .inst_data_ok_i(inst_data_ok_i),
        .if_valid_o(if_valid), .if_inst_o(if_inst), .if_pc_o(if_pc)
    );

    decode_stage u_decode (
        .cpu_clk_50m_i(cpu_clk_50m_i), .rst_n_i(rst_n_i),
        .if_valid_i(if_valid), .if_inst_i(if_inst), .if_pc_i(if_pc),
        .ra1_o(ra1), .ra2_o(ra2), .rd1_i(rd1), .rd2_i(rd2),
        .exe_fwd_wreg_i(exe_fwd_wreg), .exe_fwd_wa_i(exe_fwd_wa),
        .exe_fwd_wd_i(exe_fwd_wd),
        .id_exe(id_exe.source)
    );

    // written from the exe/wb register, that is the wb stage
    regfile u_regfile (
        .cpu_clk_50m_i(cpu_clk_50m_i), .rst_n_i(rst_n_i),
        .we_i(exe_wb.wreg), .wa_i(exe_wb.wa), .wd_i(exe_wb.wd),
        .ra1_i(ra1), .ra2_i(ra2), .rd1_o(rd1), .rd2_o(rd2)
    );

    exe_stage u_exe (
        .cpu_clk_50m_i(cpu_clk_50m_i), .rst_n_i(rst_n_i),
        .id_exe(id_exe.sink), .exe_wb(exe_wb.source),
        .exe_fwd_wreg_o(exe_fwd_wreg), .exe_fwd_wa_o(exe_fwd_wa),
        .exe_fwd_wd_o(exe_fwd_wd)
    );

    // trace ports
    assign debug_wb_pc_o       = exe_wb.pc;
    assign debug_wb_rf_wen_o   = {4{exe_wb.wreg}}; // full word writes only
    assign debug_wb_rf_wnum_o  = exe_wb.wa;
    assign debug_wb_rf_wdata_o = exe_wb.wd;

endmodule

`default_nettype wire

/* rtl/exe_stage.sv */
`default_nettype none

module exe_stage (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_n_i,

    id_exe_if.sink                  id_exe,
    exe_wb_if.source                exe_wb,

    // forwarding back into decode
    output logic                    exe_fwd_wreg_o,
    output minimips_pkg::reg_addr_t exe_fwd_wa_o,
    output minimips_pkg::word_t     exe_fwd_wd_o
);

    minimips_pkg::word_t alu_res;
    logic                wr_en;
    logic                lt;

    assign lt    = $signed(id_exe.src1) < $signed(id_exe.src2);
    assign wr_en = id_exe.valid & id_exe.wreg; // bubbles never write

    always_comb begin
        case (id_exe.aluop)
            minimips_pkg::ALU_ADD: alu_res = id_exe.src1 + id_exe.src2;
            minimips_pkg::ALU_SUB: alu_res = id_exe.src1 - id_exe.src2;
            minimips_pkg::ALU_AND: alu_res = id_exe.src1 & id_exe.src2;
            minimips_pkg::ALU_OR:  alu_res = id_exe.src1 | id_exe.src2;
            minimips_pkg::ALU_XOR: alu_res = id_exe.src1 ^ id_exe.src2;
            minimips_pkg::ALU_SLT: begin
                alu_res = {{(minimips_pkg::WORD_W-1){1'b0}}, lt};
            end
            minimips_pkg::ALU_SLL: alu_res = id_exe.src2 << id_exe.src1[4:0];
            minimips_pkg::ALU_LUI: alu_res = {id_exe.src2[15:0], 16'h0000};
            default:               alu_res = '0;
        endcase
    end

    assign exe_fwd_wreg_o = wr_en;
    assign exe_fwd_wa_o   = id_exe.wa;
    assign exe_fwd_wd_o   = alu_res;

    always_ff @(posedge cpu_clk_50m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe_wb.wreg <= 1'b0;
        end else begin
            exe_wb.wreg <= wr_en;
        end
    end

    always_ff @(posedge cpu_clk_50m_i) begin
        exe_wb.wa <= id_exe.wa;
        exe_wb.wd <= alu_res;
        exe_wb.pc <= id_exe.pc;
    end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`default_nettype none

module regfile (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_n_i,
    input  logic                    we_i,
    input  minimips_pkg::reg_addr_t wa_i,
    input  minimips_pkg::word_t     wd_i,
    input  minimips_pkg::reg_addr_t ra1_i,
    input  minimips_pkg::reg_addr_t ra2_i,
    output minimips_pkg::word_t     rd1_o,
    output minimips_pkg::word_t     rd2_o
);

    minimips_pkg::word_t regs [32];

    always_ff @(posedge cpu_clk_50m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // r0 reads zero, same-cycle write is passed through
    assign rd1_o = (ra1_i == '0)                  ? '0   :
                   (we_i && wa_i == ra1_i)         ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0)                  ? '0   :
                   (we_i && wa_i == ra2_i)         ? wd_i : regs[ra2_i];

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  logic                    cpu_clk_50m_i,
    input  logic                    rst_n_i,

    // from if/id
    input  logic                    if_valid_i,
    input  minimips_pkg::word_t     if_inst_i,
    input  minimips_pkg::word_t     if_pc_i,

    // register file read
    output minimips_pkg::reg_addr_t ra1_o,
    output minimips_pkg::reg_addr_t ra2_o,
    input  minimips_pkg::word_t     rd1_i,
    input  minimips_pkg::word_t     rd2_i,

    // result of the instruction now in exe
    input  logic                    exe_fwd_wreg_i,
    input  minimips_pkg::reg_addr_t exe_fwd_wa_i,
    input  minimips_pkg::word_t     exe_fwd_wd_i,

    id_exe_if.source                id_exe
);

    minimips_pkg::opcode_e   op;
    minimips_pkg::funct_e    fn;
    minimips_pkg::reg_addr_t rs;
    minimips_pkg::reg_addr_t rt;
    minimips_pkg::reg_addr_t rd;
    minimips_pkg::reg_addr_t sa;
    logic [15:0]             imm;
    minimips_pkg::word_t     sext_imm;
    minimips_pkg::word_t     zext_imm;
    minimips_pkg::word_t     rs_val;
    minimips_pkg::word_t     rt_val;

    minimips_pkg::aluop_e    aluop;
    minimips_pkg::word_t     src1;
    minimips_pkg::word_t     src2;
    minimips_pkg::reg_addr_t wa;
    logic                    known;

    assign op  = minimips_pkg::opcode_e'(if_inst_i[31:26]);
    assign fn  = minimips_pkg::funct_e'(if_inst_i[5:0]);
    assign rs  = if_inst_i[25:21];
    assign rt  = if_inst_i[20:16];
    assign rd  = if_inst_i[15:11];
    assign sa  = if_inst_i[10:6];
    assign imm = if_inst_i[15:0];

    assign sext_imm = {{16{imm[15]}}, imm};
    assign zext_imm = {16'h0000, imm};

    assign ra1_o = rs;
    assign ra2_o = rt;

    // exe has priority, wb is covered by regfile write-through
    assign rs_val = (exe_fwd_wreg_i && exe_fwd_wa_i == rs) ? exe_fwd_wd_i : rd1_i;
    assign rt_val = (exe_fwd_wreg_i && exe_fwd_wa_i == rt) ? exe_fwd_wd_i : rd2_i;

    always_comb begin
        aluop = minimips_pkg::ALU_ADD;
        src1  = rs_val;
        src2  = rt_val;
        wa    = rd;
        known = 1'b1;
        case (op)
            minimips_pkg::OP_SPECIAL: begin
                case (fn)
                    minimips_pkg::FN_ADDU: aluop = minimips_pkg::ALU_ADD;
                    minimips_pkg::FN_SUBU: aluop = minimips_pkg::ALU_SUB;
                    minimips_pkg::FN_AND:  aluop = minimips_pkg::ALU_AND;
                    minimips_pkg::FN_OR:   aluop = minimips_pkg::ALU_OR;
                    minimips_pkg::FN_XOR:  aluop = minimips_pkg::ALU_XOR;
                    minimips_pkg::FN_SLT:  aluop = minimips_pkg::ALU_SLT;
                    minimips_pkg::FN_SLL: begin
                        aluop = minimips_pkg::ALU_SLL;
                        src1  = {27'b0, sa}; // shift amount from the instruction
                    end
                    default: known = 1'b0;
                endcase
            end
            minimips_pkg::OP_ADDIU: begin
                aluop = minimips_pkg::ALU_ADD;
                src2  = sext_imm;
                wa    = rt;
            end
            minimips_pkg::OP_ANDI: begin
                aluop = minimips_pkg::ALU_AND;
                src2  = zext_imm;
                wa    = rt;
            end
            minimips_pkg::OP_ORI: begin
                aluop = minimips_pkg::ALU_OR;
                src2  = zext_imm;
                wa    = rt;
            end
            minimips_pkg::OP_XORI: begin
                aluop = minimips_pkg::ALU_XOR;
                src2  = zext_imm;
                wa    = rt;
            end
            minimips_pkg::OP_LUI: begin
                aluop = minimips_pkg::ALU_LUI;
                src2  = zext_imm; // shifted up in exe
                wa    = rt;
            end
            default: known = 1'b0; // anything else is a no-op
        endcase
    end

    always_ff @(posedge cpu_clk_50m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_exe.valid <= 1'b0;
            id_exe.wreg  <= 1'b0;
        end else begin
            id_exe.valid <= if_valid_i;
            id_exe.wreg  <= known && (wa != '0); // r0 writes dropped here
        end
    end

    always_ff @(posedge cpu_clk_50m_i) begin
        id_exe.aluop <= aluop;
        id_exe.src1  <= src1;
        id_exe.src2  <= src2;
        id_exe.wa    <= wa;
        id_exe.pc    <= if_pc_i;
    end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage #(
    parameter minimips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                cpu_clk_50m_i,
    input  logic                rst_n_i,

    // sram-like instruction port
    output logic                inst_req_o,
    output minimips_pkg::word_t inst_addr_o,
    input  minimips_pkg::word_t inst_rdata_i,
    input  logic                inst_data_ok_i,

    // if/id register
    output logic                if_valid_o,
    output minimips_pkg::word_t if_inst_o,
    output minimips_pkg::word_t if_pc_o
);

    minimips_pkg::word_t pc;
    logic                xfer;

    // a transfer completes when req and data_ok meet at an edge
    assign xfer        = inst_req_o & inst_data_ok_i;
    assign inst_addr_o = pc; // held until the transfer completes

    always_ff @(posedge cpu_clk_50m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_req_o <= 1'b0;
            pc         <= RESET_PC;
            if_valid_o <= 1'b0;
        end else begin
            inst_req_o <= 1'b1; // stays up once out of reset
            if_valid_o <= xfer; // no data this cycle gives a bubble
            if (xfer) begin
                pc <= pc + minimips_pkg::word_t'(4);
            end
        end
    end

    // instruction and its pc, qualified by if_valid_o
    always_ff @(posedge cpu_clk_50m_i) begin
        if (xfer) begin
            if_inst_o <= inst_rdata_i;
            if_pc_o   <= pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/minimips_ifs.sv */
`default_nettype none

// decode to execute, one instruction per cycle
interface id_exe_if;
    logic                      valid;
    minimips_pkg::aluop_e      aluop;
    minimips_pkg::word_t       src1;
    minimips_pkg::word_t       src2;
    minimips_pkg::reg_addr_t   wa;
    logic                      wreg;
    minimips_pkg::word_t       pc;

    modport source (
        output valid, aluop, src1, src2, wa, wreg, pc
    );

    modport sink (
        input valid, aluop, src1, src2, wa, wreg, pc
    );
endinterface

// execute result towards register file and trace
interface exe_wb_if;
    logic                      wreg; // already qualified by valid
    minimips_pkg::reg_addr_t   wa;
    minimips_pkg::word_t       wd;
    minimips_pkg::word_t       pc;

    modport source (
        output wreg, wa, wd, pc
    );

    modport sink (
        input wreg, wa, wd, pc
    );
endinterface

`default_nettype wire

/* rtl/minimips_pkg.sv */
`default_nettype none

package minimips_pkg;

    parameter int WORD_W     = 32;
    parameter int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDIU   = 6'b001001,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field of SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5, // signed compare
        ALU_SLL = 4'd6, // src2 << src1[4:0]
        ALU_LUI = 4'd7  // imm into upper half
    } aluop_e;

endpackage

`default_nettype wire
